//--- all.f
source/countdown_pkg.sv
source/bcd_time_convert.sv
source/time_difference.sv
source/rtc_apb_master.sv
source/countdown_sequencer.sv
source/countdown_timer.sv
tb/rtc_apb_model.sv
tb/tb_countdown_timer.sv

//--- Bender.yml
package:
  name: countdown_timer

sources:
  - source/countdown_pkg.sv
  - source/bcd_time_convert.sv
  - source/time_difference.sv
  - source/rtc_apb_master.sv
  - source/countdown_sequencer.sv
  - source/countdown_timer.sv

  - target: test
    files:
      - tb/rtc_apb_model.sv
      - tb/tb_countdown_timer.sv

//--- tb/tb_countdown_timer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_countdown_timer
    import countdown_pkg::*;
();

    localparam int                    CLK_PERIOD      = 8;
    localparam int                    CYCLE_LIMIT     = 4000;
    localparam logic [ADDR_WIDTH-1:0] CTRL_ADDR       = 8'h00;
    localparam logic [ADDR_WIDTH-1:0] COUNT_BASE_ADDR = 8'h41;
    localparam int                    HALT_BIT        = 3;

    logic      clk;
    logic      reset;
    logic      start;
    logic      ring_ack;
    bcd_time_t set_time;
    bcd_time_t elapsed_time;
    bcd_time_t remaining_time;
    apb_req_t  apb_req;
    apb_rsp_t  apb_rsp;
    logic      ring;
    logic      active;

    int        errors = 0;
    int        cycles = 0;
    int        log_index = 0;
    bcd_time_t set_run;
    bcd_time_t hist [0:2];
    logic      unhalt_seen;
    logic      counting_exp;
    logic      ring_exp;

    countdown_timer #(
        .CTRL_ADDR       (CTRL_ADDR),
        .COUNT_BASE_ADDR (COUNT_BASE_ADDR),
        .HALT_BIT        (HALT_BIT)
    ) uut (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .ring_ack       (ring_ack),
        .set_time       (set_time),
        .elapsed_time   (elapsed_time),
        .apb_rsp        (apb_rsp),
        .apb_req        (apb_req),
        .remaining_time (remaining_time),
        .ring           (ring),
        .active         (active)
    );

    rtc_apb_model rtc (
        .clk     (clk),
        .reset   (reset),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////
    // reference model

    function automatic int to_seconds(input bcd_time_t t);
        int h;
        int m;
        int s;
        h = t.hours[7:4] * 10 + t.hours[3:0];
        m = t.minutes[7:4] * 10 + t.minutes[3:0];
        s = t.seconds[7:4] * 10 + t.seconds[3:0];
        return h * 3600 + m * 60 + s;
    endfunction

    function automatic bcd_time_t to_bcd(input int total);
        bcd_time_t t;
        int        h;
        int        m;
        int        s;
        h = total / 3600;
        m = (total / 60) % 60;
        s = total % 60;
        t.hours   = {4'(h / 10), 4'(h % 10)};
        t.minutes = {4'(m / 10), 4'(m % 10)};
        t.seconds = {4'(s / 10), 4'(s % 10)};
        return t;
    endfunction

    // whole seconds saturating at zero
    function automatic bcd_time_t expected_remaining(input bcd_time_t set, input bcd_time_t el);
        int diff;
        diff = to_seconds(set) - to_seconds(el);
        if (diff <= 0)
            return '0;
        return to_bcd(diff);
    endfunction

    always @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            hist[0]      <= '0;
            hist[1]      <= '0;
            hist[2]      <= '0;
            unhalt_seen  <= 1'b0;
            counting_exp <= 1'b0;
            ring_exp     <= 1'b0;
        end
        else
        begin
            hist[0] <= elapsed_time;
            hist[1] <= hist[0];
            hist[2] <= hist[1];
            // end of the write that clears the halt bit
            unhalt_seen <= apb_req.psel && apb_req.penable && apb_rsp.pready &&
                           apb_req.pwrite && apb_req.paddr == CTRL_ADDR &&
                           !apb_req.pwdata[HALT_BIT];
            if (unhalt_seen)
                counting_exp <= 1'b1;
            if (ring_exp && ring_ack)
            begin
                counting_exp <= 1'b0;
                ring_exp     <= 1'b0;
            end
            else if (counting_exp && expected_remaining(set_run, hist[1]) == '0)
                ring_exp <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////
    // checks

    always @(negedge clk)
    begin : output_checks
        bcd_time_t rem_exp;
        rem_exp = counting_exp ? expected_remaining(set_run, hist[2]) : bcd_time_t'(0);
        if (!reset)
        begin
            assert (remaining_time == rem_exp)
            else
            begin
                errors++;
                $display("[ERROR] %0t remaining_time %h, expected %h",
                         $time, remaining_time, rem_exp);
            end
            assert (ring == ring_exp)
            else
            begin
                errors++;
                $display("[ERROR] %0t ring %b, expected %b", $time, ring, ring_exp);
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        apb_req.psel && !apb_req.penable |=> apb_req.psel && apb_req.penable)
    else
    begin
        errors++;
        $display("[ERROR] %0t setup phase not followed by access phase", $time);
    end

    // access held steady while pready is low
    assert property (@(posedge clk) disable iff (reset)
        apb_req.penable && !apb_rsp.pready |=>
        apb_req.penable && $stable(apb_req.paddr) && $stable(apb_req.pwrite))
    else
    begin
        errors++;
        $display("[ERROR] %0t access phase dropped or changed before pready", $time);
    end

    assert property (@(posedge clk) disable iff (reset)
        apb_req.penable && apb_rsp.pready |=> !apb_req.psel)
    else
    begin
        errors++;
        $display("[ERROR] %0t psel not low between transfers", $time);
    end

    assert property (@(posedge clk) disable iff (reset) ring |-> active)
    else
    begin
        errors++;
        $display("[ERROR] %0t ring high while active is low", $time);
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout: test did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////
    // stimulus

    task automatic expect_quiet(input int n);
        int base;
        base = rtc.log_count;
        repeat (n)
        begin
            @(negedge clk);
            assert (!apb_req.psel && !apb_req.penable && !ring && !active &&
                    remaining_time == '0)
            else
            begin
                errors++;
                $display("[ERROR] %0t outputs not idle, psel %b active %b remaining %h",
                         $time, apb_req.psel, active, remaining_time);
            end
        end
        assert (rtc.log_count == base)
        else
        begin
            errors++;
            $display("[ERROR] %0t %0d transfers while idle", $time, rtc.log_count - base);
        end
    endtask

    task automatic press_start(input bcd_time_t t);
        set_time = t;
        set_run  = t;
        @(negedge clk);
        start = 1'b1;
        repeat (2) @(negedge clk);
        start = 1'b0;
    endtask

    task automatic fetch_transfer(output logic [16:0] entry);
        while (rtc.log_count <= log_index)
            @(negedge clk);
        entry = rtc.log_mem[log_index];
        log_index++;
    endtask

    task automatic check_write(input logic [7:0] addr, input logic [7:0] data);
        logic [16:0] entry;
        fetch_transfer(entry);
        assert (entry == {1'b1, addr, data})
        else
        begin
            errors++;
            $display("[ERROR] %0t transfer %h, expected write %h to %h", $time, entry, data, addr);
        end
    endtask

    task automatic check_read(input logic [7:0] addr, output logic [7:0] data);
        logic [16:0] entry;
        fetch_transfer(entry);
        data = entry[7:0];
        assert (entry[16:8] == {1'b0, addr})
        else
        begin
            errors++;
            $display("[ERROR] %0t transfer %h, expected read of %h", $time, entry, addr);
        end
    endtask

    task automatic run_countdown(input bcd_time_t t, input bcd_time_t first_elapsed);
        logic [7:0] ctrl;
        int         secs;
        int         extra;
        elapsed_time = '0;
        press_start(t);
        while (!active)
            @(negedge clk);
        for (int i = 0; i < 3; i++)
            check_write(COUNT_BASE_ADDR + 8'(i), 8'h00);
        check_read(CTRL_ADDR, ctrl);
        check_write(CTRL_ADDR, ctrl & ~(8'h01 << HALT_BIT));
        // rtc ticks with uneven spacing and runs a little past zero
        secs  = to_seconds(first_elapsed);
        extra = 0;
        while (extra < 3)
        begin
            elapsed_time = to_bcd(secs);
            repeat (1 + secs % 3) @(negedge clk);
            secs++;
            if (ring)
                extra++;
        end
        ring_ack = 1'b1;
        @(negedge clk);
        assert (!ring && !active)
        else
        begin
            errors++;
            $display("[ERROR] %0t ring %b active %b after ring_ack", $time, ring, active);
        end
        check_read(CTRL_ADDR, ctrl);
        check_write(CTRL_ADDR, ctrl | (8'h01 << HALT_BIT));
        repeat (2) @(negedge clk);
        ring_ack     = 1'b0;
        elapsed_time = '0;
        repeat (3) @(negedge clk);
    endtask

    initial
    begin
        reset        = 1'b1;
        start        = 1'b0;
        ring_ack     = 1'b0;
        set_time     = '0;
        elapsed_time = '0;
        set_run      = '0;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        expect_quiet(10);
        press_start(24'h00_00_00);
        expect_quiet(20);

        run_countdown(24'h00_00_05, 24'h00_00_00);
        run_countdown(24'h00_01_02, 24'h00_00_58);
        run_countdown(24'h02_00_01, 24'h01_59_57);
        run_countdown(24'h10_30_00, 24'h10_29_56);

        $display("errors: %0d, apb transfers logged: %0d", errors, rtc.log_count);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/rtc_apb_model.sv
`timescale 1ns/1ps
`default_nettype none

module rtc_apb_model
    import countdown_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire apb_req_t apb_req,
    output apb_rsp_t      apb_rsp
);

    localparam logic [31:0] SEED      = 32'h3b31_a6d7;
    localparam int          NUM_REGS  = 1 << ADDR_WIDTH;
    localparam int          LOG_DEPTH = 64;

    logic [DATA_WIDTH-1:0] regs [0:NUM_REGS-1];
    // write flag, address, data moved
    logic [16:0]           log_mem [0:LOG_DEPTH-1];
    int                    log_count;
    logic [31:0]           lfsr;
    logic [1:0]            wait_cnt;
    logic                  pready_q;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    initial
    begin
        for (int a = 0; a < NUM_REGS; a++)
            regs[a] = 8'(a * 37) ^ 8'h6c;
    end

    always @(posedge clk or posedge reset)
    begin : bus_side
        logic [31:0] next_lfsr;
        logic [1:0]  draw;
        if (reset)
        begin
            lfsr      <= SEED;
            wait_cnt  <= '0;
            pready_q  <= 1'b0;
            log_count <= 0;
        end
        else if (apb_req.psel && !apb_req.penable)
        begin
            // two fresh bits give 0 to 3 wait cycles
            draw[0]   = lfsr[0];
            next_lfsr = lfsr_step(lfsr);
            draw[1]   = next_lfsr[0];
            lfsr     <= lfsr_step(next_lfsr);
            wait_cnt <= draw;
            pready_q <= (draw == 2'd0);
        end
        else if (apb_req.psel && apb_req.penable && pready_q)
        begin
            pready_q <= 1'b0;
            if (apb_req.pwrite)
                regs[apb_req.paddr] <= apb_req.pwdata;
            if (log_count < LOG_DEPTH)
                log_mem[log_count] <= {apb_req.pwrite, apb_req.paddr,
                                       apb_req.pwrite ? apb_req.pwdata : regs[apb_req.paddr]};
            log_count <= log_count + 1;
        end
        else if (apb_req.psel && apb_req.penable)
        begin
            wait_cnt <= wait_cnt - 2'd1;
            pready_q <= (wait_cnt == 2'd1);
        end
    end

    assign apb_rsp.prdata = regs[apb_req.paddr];
    assign apb_rsp.pready = pready_q;

endmodule

`default_nettype wire

//--- source/countdown_timer.sv
`timescale 1ns/1ps
`default_nettype none

module countdown_timer
    import countdown_pkg::*;
#(
    parameter logic [ADDR_WIDTH-1:0] CTRL_ADDR       = 8'h00,
    parameter logic [ADDR_WIDTH-1:0] COUNT_BASE_ADDR = 8'h41,
    parameter int                    HALT_BIT        = 3
) (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      start,
    input  wire logic      ring_ack,
    input  wire bcd_time_t set_time,
    input  wire bcd_time_t elapsed_time,
    input  wire apb_rsp_t  apb_rsp,
    output apb_req_t       apb_req,
    output bcd_time_t      remaining_time,
    output logic           ring,
    output logic           active
);

    bin_time_t set_conv;
    bin_time_t set_hold;
    bin_time_t elapsed_bin;
    bin_time_t remaining_bin;
    bcd_time_t remaining_bcd;
    logic      zero;
    logic      capture;
    logic      counting;
    logic      op_valid;
    logic      op_done;
    rtc_op_t   op;

    bcd_time_convert #(.TO_BINARY(1'b1)) u_set_conv (
        .clk      (clk),
        .reset    (reset),
        .time_in  (set_time),
        .time_out (set_conv)
    );

    // switch value frozen at release of start
    always_ff @(posedge clk)
    begin
        if (capture)
            set_hold <= set_conv;
    end

    bcd_time_convert #(.TO_BINARY(1'b1)) u_elapsed_conv (
        .clk      (clk),
        .reset    (reset),
        .time_in  (elapsed_time),
        .time_out (elapsed_bin)
    );

    time_difference u_sub (
        .clk       (clk),
        .reset     (reset),
        .set_time  (set_hold),
        .elapsed   (elapsed_bin),
        .remaining (remaining_bin),
        .zero      (zero)
    );

    bcd_time_convert #(.TO_BINARY(1'b0)) u_remaining_conv (
        .clk      (clk),
        .reset    (reset),
        .time_in  (remaining_bin),
        .time_out (remaining_bcd)
    );

    countdown_sequencer #(
        .CTRL_ADDR       (CTRL_ADDR),
        .COUNT_BASE_ADDR (COUNT_BASE_ADDR),
        .HALT_BIT        (HALT_BIT)
    ) u_seq (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .ring_ack (ring_ack),
        .set_bin  (set_hold),
        .zero     (zero),
        .op_valid (op_valid),
        .op       (op),
        .op_done  (op_done),
        .capture  (capture),
        .counting (counting),
        .ring     (ring),
        .active   (active)
    );

    rtc_apb_master u_apb (
        .clk      (clk),
        .reset    (reset),
        .op_valid (op_valid),
        .op       (op),
        .op_done  (op_done),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp)
    );

    // blank display outside a run
    assign remaining_time = counting ? remaining_bcd : '0;

endmodule

`default_nettype wire

//--- source/countdown_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module countdown_sequencer
    import countdown_pkg::*;
#(
    parameter logic [ADDR_WIDTH-1:0] CTRL_ADDR       = 8'h00,
    parameter logic [ADDR_WIDTH-1:0] COUNT_BASE_ADDR = 8'h41,
    parameter int                    HALT_BIT        = 3
) (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      start,
    input  wire logic      ring_ack,
    input  wire bin_time_t set_bin,
    input  wire logic      zero,
    output logic           op_valid,
    output rtc_op_t        op,
    input  wire logic      op_done,
    output logic           capture,
    output logic           counting,
    output logic           ring,
    output logic           active
);

    localparam int NUM_COUNT_REGS = 3;

    typedef enum logic [3:0] {
        st_idle,
        st_press,
        st_check,
        st_clear,
        st_unhalt,
        st_count,
        st_ring,
        st_halt,
        st_release
    } seq_state_t;

    seq_state_t state;
    seq_state_t state_next;
    logic [1:0] clear_index;
    logic       last_clear;

    assign last_clear = (clear_index == 2'(NUM_COUNT_REGS - 1));

    ////////////////////////////////////////////////////
    // state machine

    always_comb
    begin
        state_next = state;
        case (state)
            st_idle:
            begin
                if (start)
                    state_next = st_press;
            end
            // wait for the button to come back up
            st_press:
            begin
                if (!start)
                    state_next = st_check;
            end
            st_check:
                state_next = (set_bin == '0) ? st_idle : st_clear;
            st_clear:
            begin
                if (op_done && last_clear)
                    state_next = st_unhalt;
            end
            st_unhalt:
            begin
                if (op_done)
                    state_next = st_count;
            end
            st_count:
            begin
                if (zero)
                    state_next = st_ring;
            end
            st_ring:
            begin
                if (ring_ack)
                    state_next = st_halt;
            end
            st_halt:
            begin
                if (op_done)
                    state_next = st_release;
            end
            st_release:
            begin
                if (!ring_ack)
                    state_next = st_idle;
            end
            default:
                state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= st_idle;
        else
            state <= state_next;
    end

    // walks the count registers
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            clear_index <= '0;
        else if (state == st_clear && op_done)
            clear_index <= last_clear ? 2'd0 : clear_index + 2'd1;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            active   <= 1'b0;
            counting <= 1'b0;
            ring     <= 1'b0;
        end
        else if (state == st_check && set_bin != '0)
            active <= 1'b1;
        else if (state == st_unhalt && op_done)
            counting <= 1'b1;
        else if (state == st_count && zero)
            ring <= 1'b1;
        else if (state == st_ring && ring_ack)
        begin
            active   <= 1'b0;
            counting <= 1'b0;
            ring     <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////
    // rtc operation requests

    always_comb
    begin
        op_valid = 1'b0;
        op       = '{kind: op_write, addr: CTRL_ADDR, wdata: '0, bit_index: 3'(HALT_BIT)};
        case (state)
            st_clear:
            begin
                op_valid = 1'b1;
                op.addr  = COUNT_BASE_ADDR + ADDR_WIDTH'(clear_index);
            end
            // run the rtc
            st_unhalt:
            begin
                op_valid = 1'b1;
                op.kind  = op_clear_bit;
            end
            st_halt:
            begin
                op_valid = 1'b1;
                op.kind  = op_set_bit;
            end
            default:
                op_valid = 1'b0;
        endcase
    end

    assign capture = (state == st_press);

endmodule

`default_nettype wire

//--- source/rtc_apb_master.sv
`timescale 1ns/1ps
`default_nettype none

module rtc_apb_master
    import countdown_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     op_valid,
    input  wire rtc_op_t  op,
    output logic          op_done,
    output apb_req_t      apb_req,
    input  wire apb_rsp_t apb_rsp
);

    typedef enum logic [2:0] {
        m_idle,
        m_rd_setup,
        m_rd_access,
        m_gap,
        m_wr_setup,
        m_wr_access,
        m_done
    } master_state_t;

    master_state_t         state;
    master_state_t         state_next;
    logic                  transfer_end;
    logic [DATA_WIDTH-1:0] rdata_q;
    logic [DATA_WIDTH-1:0] merged;

    assign transfer_end = apb_req.penable && apb_rsp.pready;

    ////////////////////////////////////////////////////
    // transfer sequencing

    always_comb
    begin
        state_next = state;
        case (state)
            m_idle:
            begin
                if (op_valid)
                    state_next = (op.kind == op_write) ? m_wr_setup : m_rd_setup;
            end
            m_rd_setup:
                state_next = m_rd_access;
            m_rd_access:
            begin
                if (transfer_end)
                    state_next = m_gap;
            end
            // psel drops between read and write
            m_gap:
                state_next = m_wr_setup;
            m_wr_setup:
                state_next = m_wr_access;
            m_wr_access:
            begin
                if (transfer_end)
                    state_next = m_done;
            end
            m_done:
                state_next = m_idle;
            default:
                state_next = m_idle;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= m_idle;
        else
            state <= state_next;
    end

    always_ff @(posedge clk)
    begin
        if (state == m_rd_access && transfer_end)
            rdata_q <= apb_rsp.prdata;
    end

    // read value with the one bit forced
    always_comb
    begin
        merged                = rdata_q;
        merged[op.bit_index]  = (op.kind == op_set_bit);
    end

    ////////////////////////////////////////////////////
    // bus outputs

    always_comb
    begin
        apb_req.psel    = state inside {m_rd_setup, m_rd_access, m_wr_setup, m_wr_access};
        apb_req.penable = state inside {m_rd_access, m_wr_access};
        apb_req.pwrite  = state inside {m_wr_setup, m_wr_access};
        apb_req.paddr   = op.addr;
        apb_req.pwdata  = (op.kind == op_write) ? op.wdata : merged;
    end

    assign op_done = (state == m_done);

endmodule

`default_nettype wire

//--- source/time_difference.sv
`timescale 1ns/1ps
`default_nettype none

module time_difference
    import countdown_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire bin_time_t set_time,
    input  wire bin_time_t elapsed,
    output bin_time_t      remaining,
    output logic           zero
);

    logic                   invalid;
    logic                   expired;
    logic                   sec_borrow;
    logic                   min_borrow;
    logic [FIELD_WIDTH-1:0] sec_diff;
    logic [FIELD_WIDTH-1:0] min_diff;
    logic [FIELD_WIDTH-1:0] hour_diff;

    // any ff field poisons the result
    assign invalid = (set_time.hours == '1) || (set_time.minutes == '1) ||
                     (set_time.seconds == '1) || (elapsed.hours == '1) ||
                     (elapsed.minutes == '1) || (elapsed.seconds == '1);

    // fields are below 60 so a plain compare of the concatenation orders times
    assign expired = {elapsed.hours, elapsed.minutes, elapsed.seconds} >=
                     {set_time.hours, set_time.minutes, set_time.seconds};

    ////////////////////////////////////////////////////
    // seconds borrow into minutes, minutes into hours

    always_comb
    begin
        sec_borrow = set_time.seconds < elapsed.seconds;
        sec_diff   = set_time.seconds - elapsed.seconds;
        if (sec_borrow)
            sec_diff = sec_diff + FIELD_WIDTH'(MAX_SECONDS + 1);

        min_borrow = set_time.minutes < (elapsed.minutes + FIELD_WIDTH'(sec_borrow));
        min_diff   = set_time.minutes - elapsed.minutes - FIELD_WIDTH'(sec_borrow);
        if (min_borrow)
            min_diff = min_diff + FIELD_WIDTH'(MAX_MINUTES + 1);

        hour_diff = set_time.hours - elapsed.hours - FIELD_WIDTH'(min_borrow);
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            remaining <= '0;
            zero      <= 1'b1;
        end
        else if (invalid || expired)
        begin
            remaining <= '0;
            zero      <= 1'b1;
        end
        else
        begin
            remaining <= '{hours: hour_diff, minutes: min_diff, seconds: sec_diff};
            zero      <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- source/bcd_time_convert.sv
`timescale 1ns/1ps
`default_nettype none

module bcd_time_convert
    import countdown_pkg::*;
#(
    parameter bit TO_BINARY = 1'b1
) (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic [3*FIELD_WIDTH-1:0] time_in,
    output logic      [3*FIELD_WIDTH-1:0] time_out
);

    logic [FIELD_WIDTH-1:0] hours_in;
    logic [FIELD_WIDTH-1:0] minutes_in;
    logic [FIELD_WIDTH-1:0] seconds_in;
    logic [FIELD_WIDTH-1:0] hours_c;
    logic [FIELD_WIDTH-1:0] minutes_c;
    logic [FIELD_WIDTH-1:0] seconds_c;

    function automatic logic [FIELD_WIDTH-1:0] bcd_to_bin(
        input logic [FIELD_WIDTH-1:0] bcd,
        input int                     limit
    );
        logic [FIELD_WIDTH-1:0] value;
        value = FIELD_WIDTH'(bcd[7:4]) * FIELD_WIDTH'(10) + FIELD_WIDTH'(bcd[3:0]);
        // bad digit or out of range
        if (bcd[7:4] > 4'd9 || bcd[3:0] > 4'd9 || value > limit)
            return '1;
        return value;
    endfunction

    function automatic logic [FIELD_WIDTH-1:0] bin_to_bcd(
        input logic [FIELD_WIDTH-1:0] bin,
        input int                     limit
    );
        logic [FIELD_WIDTH-1:0] tens;
        logic [FIELD_WIDTH-1:0] ones;
        tens = bin / FIELD_WIDTH'(10);
        ones = bin % FIELD_WIDTH'(10);
        if (bin > limit)
            return '1;
        return {tens[3:0], ones[3:0]};
    endfunction

    assign {hours_in, minutes_in, seconds_in} = time_in;

    always_comb
    begin
        if (TO_BINARY)
        begin
            hours_c   = bcd_to_bin(hours_in, MAX_HOURS);
            minutes_c = bcd_to_bin(minutes_in, MAX_MINUTES);
            seconds_c = bcd_to_bin(seconds_in, MAX_SECONDS);
        end
        else
        begin
            hours_c   = bin_to_bcd(hours_in, MAX_HOURS);
            minutes_c = bin_to_bcd(minutes_in, MAX_MINUTES);
            seconds_c = bin_to_bcd(seconds_in, MAX_SECONDS);
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            time_out <= '0;
        else
            time_out <= {hours_c, minutes_c, seconds_c};
    end

endmodule

`default_nettype wire

//--- source/countdown_pkg.sv
`default_nettype none

package countdown_pkg;

    localparam int FIELD_WIDTH = 8;
    localparam int ADDR_WIDTH  = 8;
    localparam int DATA_WIDTH  = 8;

    // largest valid value per field
    localparam int MAX_HOURS   = 23;
    localparam int MAX_MINUTES = 59;
    localparam int MAX_SECONDS = 59;

    ////////////////////////////////////////////////////
    // time values with ff for an invalid field

    typedef struct packed {
        logic [FIELD_WIDTH-1:0] hours;
        logic [FIELD_WIDTH-1:0] minutes;
        logic [FIELD_WIDTH-1:0] seconds;
    } bcd_time_t;

    typedef struct packed {
        logic [FIELD_WIDTH-1:0] hours;
        logic [FIELD_WIDTH-1:0] minutes;
        logic [FIELD_WIDTH-1:0] seconds;
    } bin_time_t;

    ////////////////////////////////////////////////////
    // apb bus to the rtc

    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [ADDR_WIDTH-1:0] paddr;
        logic [DATA_WIDTH-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] prdata;
        logic                  pready;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        op_write,
        op_set_bit,
        op_clear_bit
    } rtc_op_kind_t;

    // one register operation
    // bit ops are read-modify-write
    typedef struct packed {
        rtc_op_kind_t          kind;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
        logic [2:0]            bit_index;
    } rtc_op_t;

endpackage

`default_nettype wire
